// File: test/cga_patterns.txt
# test cs_word xfidb_in bint_n | expected: xfidb_out pil intrq_n (all hex)
# One line per clock; cs_word = edo,intr_cmd,idbs,bdest,lba,laa,alu_op from bit 16 down
reset 12007 0000 1f 0000 0 1
reset 1001d 0000 1f 0000 0 1
reset 1007d 0000 1f 0000 0 1
load 01886 1234 1f 0000 0 1
load 01906 8001 1f 0000 0 1
load 11086 ffff 1f ffff 0 1
load 01907 aaaa 1f 0000 0 1
load 1000d 0000 1f 1234 0 1
load 10015 0000 1f 8001 0 1
arith 10908 0000 1f 9235 0 1
arith 12007 0000 1f 0008 0 1
arith 10909 0000 1f 7fff 0 1
arith 12007 0000 1f 0000 0 1
arith 10908 0000 1f 9233 0 1
arith 12007 0000 1f 000c 0 1
arith 10111 0000 1f 0000 0 1
arith 12007 0000 1f 0003 0 1
arith 10110 0000 1f 2466 0 1
arith 12007 0000 1f 0006 0 1
logic 1010a 0000 1f 1230 0 1
logic 1010b 0000 1f 9237 0 1
logic 12007 0000 1f 000e 0 1
logic 1090c 0000 1f 8007 0 1
logic 10114 0000 1f 0000 0 1
logic 12007 0000 1f 0007 0 1
logic 10015 0000 1f 8007 0 1
intr 05007 9400 1f 0000 0 1
intr 13007 0000 18 9400 0 1
intr 00007 0000 0f 0000 c 0
intr 12007 0000 1f 00fe f 0
intr 08007 0000 1f 0000 f 0
intr 08007 0000 1f 0000 c 0
intr 08007 0000 1e 0000 a 0
intr 12007 0000 1f 000e 0 1
intr 05007 0800 1f 0000 0 1
intr 00007 0000 1f 0000 b 0
intr 08007 0000 1f 0000 b 0
intr 00007 0000 1f 0000 0 1

// File: sim.f
+incdir+rtl
rtl/cga_pkg.sv
rtl/cga_cs_if.sv
rtl/cga_dcd.sv
rtl/cga_wrf.sv
rtl/cga_alu.sv
rtl/cga_intr.sv
rtl/cga_idbctl.sv
rtl/cga.sv
test/cga_tb.sv

// File: Bender.yml
package:
  name: cga

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cga_pkg.sv
      - rtl/cga_cs_if.sv
      - rtl/cga_dcd.sv
      - rtl/cga_wrf.sv
      - rtl/cga_alu.sv
      - rtl/cga_intr.sv
      - rtl/cga_idbctl.sv
      - rtl/cga.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/cga_tb.sv

// File: test/cga_tb.sv
/*
 * Testbench for the CGA data path. Replays test/cga_patterns.txt, one line
 * per clock, and checks xfidb_out, pil and intrq_n just before each rising edge.
 */
`timescale 1ns/10ps
`default_nettype none
`include "cga_macros.svh"

module cga_tb;

  localparam int    HALF       = 20; // Half of the 40 ns period
  localparam int    RST_CYCLES = 8;
  localparam string PAT_FILE   = "test/cga_patterns.txt";

  logic                   sysclk;
  logic                   rst;
  logic [`CGA_CS_W-1:0]   cs_word;
  logic [`CGA_DATA_W-1:0] xfidb_in;
  logic [4:0]             bint_n;
  logic [`CGA_DATA_W-1:0] xfidb_out;
  logic [`CGA_PIL_W-1:0]  pil;
  logic                   intrq_n;

  string                  pat_name[$];  // One entry per pattern line
  logic [`CGA_CS_W-1:0]   pat_cs[$];
  logic [`CGA_DATA_W-1:0] pat_xin[$];
  logic [4:0]             pat_bint[$];
  logic [`CGA_DATA_W-1:0] pat_xout[$];  // Expected outputs
  logic [`CGA_PIL_W-1:0]  pat_pil[$];
  logic                   pat_intrq[$];

  bit load_ok;
  int cycles      = 0;
  int cycle_limit = 0;                  // Set once the file is read
  int checks      = 0;
  int errors      = 0;
  int tests       = 0;
  int test_errors = 0;
  int test_lines  = 0;

  cga u_cga (
    .sysclk    (sysclk),
    .rst       (rst),
    .cs_word   (cs_word),
    .xfidb_in  (xfidb_in),
    .bint_n    (bint_n),
    .xfidb_out (xfidb_out),
    .pil       (pil),
    .intrq_n   (intrq_n)
  );

  initial begin
    sysclk = 1'b0;
    forever #(HALF) sysclk = ~sysclk;
  end

  // Whole file into the queues before the run starts
  task automatic load_patterns(output bit ok);
    int          fd;
    int          n;
    int          line_no;
    string       line;
    string       name;
    logic [31:0] f_cs, f_xin, f_bint, f_xout, f_pil, f_intrq;
    ok      = 1'b1;
    line_no = 0;
    fd      = $fopen(PAT_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open pattern file %s", PAT_FILE);
      ok = 1'b0;
    end else begin
      while (ok && !$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        line_no++;
        if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") continue;
        n = $sscanf(line, "%s %h %h %h %h %h %h", name, f_cs, f_xin, f_bint,
                    f_xout, f_pil, f_intrq);
        if (n != 7) begin
          $display("Malformed line %0d in %s: 7 fields needed, %0d found",
                   line_no, PAT_FILE, n);
          ok = 1'b0;
        end else begin
          pat_name.push_back(name);
          pat_cs.push_back(f_cs[`CGA_CS_W-1:0]);
          pat_xin.push_back(f_xin[`CGA_DATA_W-1:0]);
          pat_bint.push_back(f_bint[4:0]);
          pat_xout.push_back(f_xout[`CGA_DATA_W-1:0]);
          pat_pil.push_back(f_pil[`CGA_PIL_W-1:0]);
          pat_intrq.push_back(f_intrq[0]);
        end
      end
      $fclose(fd);
      if (ok && pat_name.size() == 0) begin
        $display("Pattern file %s holds no test lines", PAT_FILE);
        ok = 1'b0;
      end
    end
  endtask

  task automatic compare_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("ERR %s %s expected %0h actual %0h", test, what, exp, act);
    end
  endtask

  task automatic report_test(input string test);
    tests++;
    $display("test %s: %0d lines, %0d errors", test, test_lines, test_errors);
    test_lines  = 0;
    test_errors = 0;
  endtask

  // Run limit, reset plus one cycle per line plus slack
  always @(posedge sysclk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, pattern replay did not finish", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    rst      = 1'b1;
    cs_word  = '0;
    xfidb_in = '0;
    bint_n   = '1;                      // No requests
    load_patterns(load_ok);
    if (load_ok) begin
      cycle_limit = RST_CYCLES + pat_name.size() + 20;
      repeat (RST_CYCLES) @(posedge sysclk);
      for (int i = 0; i < pat_name.size(); i++) begin
        @(negedge sysclk);
        rst      = 1'b0;
        cs_word  = pat_cs[i];
        xfidb_in = pat_xin[i];
        bint_n   = pat_bint[i];
        #(HALF - 1);                    // Just before the next rising edge
        if (i > 0 && pat_name[i] != pat_name[i-1]) report_test(pat_name[i-1]);
        test_lines++;
        compare_value(pat_name[i], "xfidb_out", pat_xout[i], xfidb_out);
        compare_value(pat_name[i], "pil", pat_pil[i], pil);
        compare_value(pat_name[i], "intrq_n", pat_intrq[i], intrq_n);
      end
      report_test(pat_name[pat_name.size()-1]);
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (load_ok && errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/cga.sv
/*
 * CGA data path top level. Connects decoder, register file, ALU, interrupt
 * controller and bus control; one control word is consumed per sysclk edge.
 */
`timescale 1ns/10ps
`default_nettype none
`include "cga_macros.svh"

module cga (
  input  logic                  sysclk,
  input  logic                  rst,
  input  logic [`CGA_CS_W-1:0]  cs_word,   // Control-store word
  input  logic [`CGA_DATA_W-1:0] xfidb_in, // External data bus in
  input  logic [4:0]            bint_n,    // Bus interrupts 10, 11, 12, 13, 15
  output logic [`CGA_DATA_W-1:0] xfidb_out,
  output logic [`CGA_PIL_W-1:0] pil,
  output logic                  intrq_n
);

  logic [`CGA_DATA_W-1:0] a;       // A operand
  logic [`CGA_DATA_W-1:0] b;       // B operand
  logic [`CGA_DATA_W-1:0] alu_bus;
  logic [`CGA_DATA_W-1:0] fidbi;
  logic [`CGA_DATA_W-1:0] fidbo;   // Merged internal bus
  logic [`CGA_DATA_W-1:0] picmask;
  logic [3:0]             flags;   // Zero, carry, ovf, sign

  cga_cs_if cs_if ();

  cga_dcd u_dcd (
    .cs_word (cs_word),
    .cs      (cs_if.dcd)
  );

  cga_wrf u_wrf (
    .sysclk (sysclk),
    .rst    (rst),
    .cs     (cs_if.wrf),
    .wdata  (fidbo),
    .a      (a),
    .b      (b)
  );

  cga_alu u_alu (
    .sysclk  (sysclk),
    .rst     (rst),
    .cs      (cs_if.alu),
    .a       (a),
    .b       (b),
    .fidbi   (fidbi),
    .alu_bus (alu_bus),
    .flags   (flags)
  );

  cga_intr u_intr (
    .sysclk  (sysclk),
    .rst     (rst),
    .cs      (cs_if.intr),
    .bint_n  (bint_n),
    .fidbo   (fidbo),
    .picmask (picmask),
    .pil     (pil),
    .intrq_n (intrq_n)
  );

  cga_idbctl u_idbctl (
    .cs        (cs_if.idbctl),
    .xfidb_in  (xfidb_in),
    .alu_bus   (alu_bus),
    .flags     (flags),
    .pil       (pil),
    .picmask   (picmask),
    .fidbi     (fidbi),
    .fidbo     (fidbo),
    .xfidb_out (xfidb_out)
  );

endmodule

`default_nettype wire

// File: rtl/cga_idbctl.sv
/*
 * Internal bus control. Selects the internal source, merges it with the ALU
 * output onto fidbo and drives the external bus when edo is set.
 */
`timescale 1ns/10ps
`default_nettype none
`include "cga_macros.svh"

module cga_idbctl import cga_pkg::*; (
  cga_cs_if.idbctl   cs,
  input  data_t      xfidb_in,  // External bus in
  input  data_t      alu_bus,
  input  alu_flags_t flags,
  input  pil_t       pil,
  input  data_t      picmask,
  output data_t      fidbi,     // Selected internal source
  output data_t      fidbo,     // Merged bus
  output data_t      xfidb_out  // External bus out
);

  data_t status; // Flags and current level

  // Flags in 3..0, pil in 7..4
  assign status = {{(`CGA_DATA_W - `CGA_PIL_W - $bits(alu_flags_t)){1'b0}}, pil, flags};

  always_comb begin
    case (cs.idbs)
      IDB_EXT:    fidbi = xfidb_in;
      IDB_STATUS: fidbi = status;
      IDB_MASK:   fidbi = picmask;
      default:    fidbi = '0; // ALU alone
    endcase
  end

  // Wired-OR of the sources
  assign fidbo = fidbi | alu_bus;

  assign xfidb_out = cs.edo ? fidbo : '0;

endmodule

`default_nettype wire

// File: rtl/cga_intr.sv
/*
 * Priority interrupt controller for bus levels 10, 11, 12, 13 and 15.
 * Holds pending bits and the mask; pil is the highest enabled pending level.
 */
`timescale 1ns/10ps
`default_nettype none
`include "cga_macros.svh"

module cga_intr import cga_pkg::*; (
  input  logic       sysclk,
  input  logic       rst,
  cga_cs_if.intr     cs,
  input  logic [4:0] bint_n,  // Levels 10, 11, 12, 13, 15, active low
  input  data_t      fidbo,   // Mask load source
  output data_t      picmask,
  output pil_t       pil,
  output logic       intrq_n
);

  logic [4:0] pend;   // Pending requests, same order as bint_n
  data_t      mask_q; // Bit n enables level n
  logic [4:0] act;    // Pending and enabled
  logic [4:0] top;    // One-hot of the winning request

  assign act = pend & {mask_q[15], mask_q[13], mask_q[12], mask_q[11], mask_q[10]};

  // Fixed priority, level 15 highest
  always_comb begin
    top = '0;
    pil = '0;
    if (act[4]) begin
      top[4] = 1'b1;
      pil    = pil_t'(15);
    end else if (act[3]) begin
      top[3] = 1'b1;
      pil    = pil_t'(13);
    end else if (act[2]) begin
      top[2] = 1'b1;
      pil    = pil_t'(12);
    end else if (act[1]) begin
      top[1] = 1'b1;
      pil    = pil_t'(11);
    end else if (act[0]) begin
      top[0] = 1'b1;
      pil    = pil_t'(10);
    end
  end

  always_ff @(posedge sysclk) begin
    if (rst) begin
      pend   <= '0;
      mask_q <= '0;
    end else begin
      if (cs.intr_cmd == INTR_CLEAR) begin
        pend <= (pend | ~bint_n) & ~top; // Clear beats a new request
      end else begin
        pend <= pend | ~bint_n;
      end
      if (cs.intr_cmd == INTR_LDMASK) mask_q <= fidbo;
    end
  end

  assign picmask = mask_q;
  assign intrq_n = (pil == '0);

endmodule

`default_nettype wire

// File: rtl/cga_alu.sv
/*
 * ALU with flag register. The result is combinational and goes onto the
 * internal bus under alu_drive; the flags update at the clock edge.
 */
`timescale 1ns/10ps
`default_nettype none
`include "cga_macros.svh"

module cga_alu import cga_pkg::*; (
  input  logic       sysclk,
  input  logic       rst,
  cga_cs_if.alu      cs,
  input  data_t      a,
  input  data_t      b,
  input  data_t      fidbi,   // Internal input bus
  output data_t      alu_bus, // Zero unless driving
  output alu_flags_t flags
);

  logic                 sub;    // Subtract select
  data_t                b_in;   // B or its complement
  logic [`CGA_DATA_W:0] sum;    // Extra bit for carry
  data_t                result;
  logic                 ovf;
  alu_flags_t           flags_q;

  // Shared adder, SUB as A + ~B + 1
  assign sub  = (cs.alu_op == ALU_SUB);
  assign b_in = sub ? ~b : b;
  assign sum  = {1'b0, a} + {1'b0, b_in} + {{`CGA_DATA_W{1'b0}}, sub};

  // Same-sign operands giving a result of the other sign
  assign ovf = (a[`CGA_DATA_W-1] == b_in[`CGA_DATA_W-1]) &&
               (sum[`CGA_DATA_W-1] != a[`CGA_DATA_W-1]);

  always_comb begin
    case (cs.alu_op)
      ALU_ADD, ALU_SUB: result = sum[`CGA_DATA_W-1:0];
      ALU_AND:          result = a & b;
      ALU_OR:           result = a | b;
      ALU_XOR:          result = a ^ b;
      ALU_PASS_A:       result = a;
      ALU_PASS_IDB:     result = fidbi;
      default:          result = '0; // NOP
    endcase
  end

  assign alu_bus = cs.alu_drive ? result : '0;

  always_ff @(posedge sysclk) begin
    if (rst) begin
      flags_q <= '0;
    end else begin
      case (cs.alu_op)
        ALU_ADD, ALU_SUB: begin
          flags_q.carry <= sum[`CGA_DATA_W]; // SUB: set means no borrow
          flags_q.ovf   <= ovf;
          flags_q.zero  <= (result == '0);
          flags_q.sign  <= result[`CGA_DATA_W-1];
        end
        ALU_NOP: ;                           // Flags held
        default: begin                       // Carry and ovf held
          flags_q.zero <= (result == '0);
          flags_q.sign <= result[`CGA_DATA_W-1];
        end
      endcase
    end
  end

  assign flags = flags_q;

endmodule

`default_nettype wire

// File: rtl/cga_wrf.sv
/*
 * Working register file, sixteen 16-bit registers.
 * Two combinational read ports (laa, lba) and one write port at lba.
 */
`timescale 1ns/10ps
`default_nettype none
`include "cga_macros.svh"

module cga_wrf import cga_pkg::*; (
  input  logic  sysclk,
  input  logic  rst,
  cga_cs_if.wrf cs,
  input  data_t wdata, // Merged internal bus
  output data_t a,     // A operand
  output data_t b      // B operand
);

  data_t regs [`CGA_REG_N]; // Register array

  // Write port, destination shares the B select
  always_ff @(posedge sysclk) begin
    if (rst) begin
      for (int i = 0; i < `CGA_REG_N; i++) begin
        regs[i] <= '0; // All registers read zero after reset
      end
    end else if (cs.reg_we) begin
      regs[cs.lba] <= wdata;
    end
  end

  // Read ports
  assign a = regs[cs.laa];
  assign b = regs[cs.lba]; // Old value until the edge

endmodule

`default_nettype wire

// File: rtl/cga_dcd.sv
/*
 * Control-word decoder. Splits the raw word into its fields and derives
 * the register write and ALU bus enables. Purely combinational.
 */
`timescale 1ns/10ps
`default_nettype none
`include "cga_macros.svh"

module cga_dcd import cga_pkg::*; (
  input  logic [`CGA_CS_W-1:0] cs_word, // Raw control-store word
  cga_cs_if.dcd                cs
);

  cs_word_t cw; // Typed view of the word

  // Fields picked by their macro positions
  always_comb begin
    cw.alu_op   = alu_op_e'(cs_word[`CGA_CS_ALU_OP_LO +: $bits(alu_op_e)]);
    cw.laa      = cs_word[`CGA_CS_LAA_LO +: `CGA_RSEL_W];
    cw.lba      = cs_word[`CGA_CS_LBA_LO +: `CGA_RSEL_W];
    cw.bdest    = cs_word[`CGA_CS_BDEST_LO];
    cw.idbs     = idb_src_e'(cs_word[`CGA_CS_IDBS_LO +: $bits(idb_src_e)]);
    cw.intr_cmd = intr_cmd_e'(cs_word[`CGA_CS_INTR_LO +: $bits(intr_cmd_e)]);
    cw.edo      = cs_word[`CGA_CS_EDO_LO];
  end

  // Plain fan-out
  assign cs.alu_op   = cw.alu_op;
  assign cs.laa      = cw.laa;
  assign cs.lba      = cw.lba;
  assign cs.idbs     = cw.idbs;
  assign cs.intr_cmd = cw.intr_cmd;
  assign cs.edo      = cw.edo;

  // NOP never writes back, even with bdest set
  assign cs.reg_we    = cw.bdest && (cw.alu_op != ALU_NOP);

  // PASS_IDB already takes its value from the bus,
  // so the ALU stays off the bus to avoid driving it twice
  assign cs.alu_drive = (cw.idbs == IDB_ALU) && (cw.alu_op != ALU_PASS_IDB);

endmodule

`default_nettype wire

// File: rtl/cga_cs_if.sv
/*
 * Decoded control fields, driven by the decoder once per control word and
 * read by the register file, ALU, interrupt controller and bus control.
 */
`timescale 1ns/10ps
`default_nettype none
`include "cga_macros.svh"

interface cga_cs_if import cga_pkg::*; ();

  alu_op_e   alu_op;
  rsel_t     laa;       // A operand select
  rsel_t     lba;       // B operand and destination select
  logic      reg_we;    // Write bus into lba
  logic      alu_drive; // ALU result onto the bus
  idb_src_e  idbs;
  intr_cmd_e intr_cmd;
  logic      edo;       // External bus output enable

  modport dcd    (output alu_op, laa, lba, reg_we, alu_drive, idbs, intr_cmd, edo);
  modport wrf    (input laa, lba, reg_we);
  modport alu    (input alu_op, alu_drive);
  modport intr   (input intr_cmd);
  modport idbctl (input idbs, edo);

endinterface

`default_nettype wire

// File: rtl/cga_pkg.sv
/*
 * Shared types of the CGA data path: control fields, flags and data words.
 * Imported by the decoder, the control interface and the datapath blocks.
 */
`default_nettype none
`include "cga_macros.svh"

package cga_pkg;

  typedef logic [`CGA_DATA_W-1:0] data_t; // One bus word
  typedef logic [`CGA_RSEL_W-1:0] rsel_t; // Register select
  typedef logic [`CGA_PIL_W-1:0]  pil_t;  // Interrupt level

  typedef enum logic [2:0] {
    ALU_ADD      = 3'd0,
    ALU_SUB      = 3'd1,
    ALU_AND      = 3'd2,
    ALU_OR       = 3'd3,
    ALU_XOR      = 3'd4,
    ALU_PASS_A   = 3'd5,
    ALU_PASS_IDB = 3'd6, // Result taken from the internal input bus
    ALU_NOP      = 3'd7
  } alu_op_e;

  typedef enum logic [1:0] {
    IDB_ALU    = 2'd0, // Only the ALU drives the bus
    IDB_EXT    = 2'd1,
    IDB_STATUS = 2'd2,
    IDB_MASK   = 2'd3
  } idb_src_e;

  typedef enum logic [1:0] {
    INTR_NONE   = 2'd0,
    INTR_LDMASK = 2'd1,
    INTR_CLEAR  = 2'd2,
    INTR_RSVD   = 2'd3 // Treated as NONE
  } intr_cmd_e;

  // MSB first, so alu_op lands on bit 0
  typedef struct packed {
    logic      edo;
    intr_cmd_e intr_cmd;
    idb_src_e  idbs;
    logic      bdest;
    rsel_t     lba;
    rsel_t     laa;
    alu_op_e   alu_op;
  } cs_word_t;

  typedef struct packed {
    logic sign;
    logic ovf;
    logic carry;
    logic zero; // Bit 0 of the status word
  } alu_flags_t;

endpackage

`default_nettype wire

// File: rtl/cga_macros.svh
/*
 * Architectural widths and control-word field positions of the CGA data path.
 * Included by every RTL file that sizes a port or slices the control word.
 */
`ifndef CGA_MACROS_SVH
`define CGA_MACROS_SVH

`define CGA_DATA_W 16 // Data path width
`define CGA_REG_N  16 // Working registers
`define CGA_RSEL_W 4  // Register select
`define CGA_PIL_W  4  // Interrupt level
`define CGA_CS_W   17 // Control word

// Low bit of each control-word field, packed from bit 0 upward
`define CGA_CS_ALU_OP_LO 0  // 3 bits
`define CGA_CS_LAA_LO    3  // 4 bits
`define CGA_CS_LBA_LO    7  // 4 bits
`define CGA_CS_BDEST_LO  11 // 1 bit
`define CGA_CS_IDBS_LO   12 // 2 bits
`define CGA_CS_INTR_LO   14 // 2 bits
`define CGA_CS_EDO_LO    16 // 1 bit

`endif
